// ==== hdl/board_pkg.sv ====
package board_pkg;

    // --------------------------------------------------
    // Board resources

    localparam int clk_mhz   = 50;                    // Board oscillator, MHz
    localparam int w_key     = 4;                     // Push buttons
    localparam int w_sw      = 10;                    // Slide switches
    localparam int w_led     = 18;                    // LEDR plus LEDG
    localparam int w_digit   = 4;                     // Seven-segment digits
    localparam int w_gpio    = 22;                    // GPIO header width

    // The last four LEDR carry the decimal points
    localparam int w_top_led = w_led - w_digit;       // LEDs left for the level bar

    // --------------------------------------------------
    // Microphone and level path

    localparam int w_mic     = 24;                    // INMP441 sample width
    localparam int w_level   = 16;                    // Displayed magnitude, four hex digits

    // sck period is twice this, 64 sck periods per ws frame
    localparam int i2s_sck_half = 4;                  // clk cycles per sck half period

    // --------------------------------------------------
    // Display timing

    localparam int refresh_hz  = 10000;               // slow_clk rate, display latch tick
    localparam int scan_cycles = 16;                  // clk cycles per selected digit

endpackage

// ==== hdl/board_specific_top.sv ====
`timescale 1ns/1ps

module board_specific_top
(
    input  logic                          CLOCK_50_B8A,
    input  logic                          CPU_RESET_n,   // Button, low when pressed
    input  logic [board_pkg::w_key - 1:0] KEY,           // Low when pressed
    input  logic [board_pkg::w_sw - 1:0]  SW,
    output logic [9:0]                    LEDR,          // Top four show decimal points
    output logic [7:0]                    LEDG,
    output logic [6:0]                    HEX0,          // Active low, no dp pin on board
    output logic [6:0]                    HEX1,
    output logic [6:0]                    HEX2,
    output logic [6:0]                    HEX3,
    input  logic                          UART_RX,       // Not used by this lab
    inout  wire  [board_pkg::w_gpio - 1:0] GPIO          // Microphone on GPIO[5:0]
);

    import board_pkg::*;

    logic                   clk;
    logic                   rst;
    logic                   slow_clk;                 // Refresh tick for the meter
    logic [w_key - 1:0]     top_key;                  // Active high keys
    logic [w_top_led - 1:0] top_led;
    logic [7:0]             abcdefgh;                 // Scanned segments
    logic [7:0]             hgfedcba;                 // Same, bit order reversed
    logic [w_digit - 1:0]   digit;                    // Scanned digit select
    logic [6:0]             hex_q [w_digit];          // Sticky segment copies
    logic [w_digit - 1:0]   dp;                       // Sticky decimal points

    assign clk     = CLOCK_50_B8A;
    assign rst     = ~CPU_RESET_n;
    assign top_key = ~KEY;

    // --------------------------------------------------
    // Core

    slow_clk_gen
    #(
        .fast_clk_mhz (clk_mhz),
        .slow_clk_hz  (refresh_hz)
    )
    i_slow_clk_gen
    (
        .clk      (clk),
        .rst      (rst),
        .slow_clk (slow_clk)
    );

    top i_top
    (
        .clk      (clk),
        .slow_clk (slow_clk),
        .rst      (rst),
        .key      (top_key),
        .sw       (SW[w_sw - 2:0]),                   // Top switch stays spare
        .led      (top_led),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .lr       (GPIO[0]),                          // Low selects left channel
        .ws       (GPIO[2]),
        .sck      (GPIO[4]),
        .sd       (GPIO[5])
    );

    assign GPIO[1] = 1'b0;                            // Microphone ground
    assign GPIO[3] = 1'b1;                            // Microphone supply

    assign {LEDR[5:0], LEDG} = top_led;               // LEDG takes the low bits

    // --------------------------------------------------
    // Static digits from the scanned display

    assign hgfedcba = {<<{abcdefgh}};                 // a lands in bit 0

    // Each HEX keeps the last pattern seen while its digit was selected
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int n = 0; n < w_digit; n++)
                hex_q[n] <= '1;                       // All segments dark
            dp <= '0;
        end
        else
        begin
            for (int n = 0; n < w_digit; n++)
            begin
                if (digit[n])
                begin
                    hex_q[n] <= ~hgfedcba[6:0];       // Board segments are active low
                    dp[n]    <= hgfedcba[7];
                end
            end
        end
    end

    assign HEX0 = hex_q[0];
    assign HEX1 = hex_q[1];
    assign HEX2 = hex_q[2];
    assign HEX3 = hex_q[3];

    assign LEDR[9:6] = dp;                            // dp of digit n on LEDR[6+n]

endmodule

// ==== hdl/inmp441_mic_i2s_receiver.sv ====
`timescale 1ns/1ps

module inmp441_mic_i2s_receiver
(
    input  logic                        clk,
    input  logic                        rst,
    output logic                        lr,           // Channel select pin of the microphone
    output logic                        ws,           // Word select, low for left half
    output logic                        sck,          // Serial bit clock
    input  logic                        sd,           // Serial data from microphone
    output logic [board_pkg::w_mic - 1:0] value,      // Last complete left sample
    output logic                        sample_valid  // One clk pulse per new sample
);

    import board_pkg::*;

    logic [$clog2(i2s_sck_half) - 1:0] div_cnt;       // sck half period divider
    logic                              sck_tick;      // sck changes this cycle
    logic                              sck_fall;      // sck goes 1 to 0
    logic                              sck_rise;      // sck goes 0 to 1
    logic [5:0]                        bit_cnt;       // sck period within 64-bit frame
    logic [5:0]                        bit_next;
    logic [w_mic - 1:0]                shift;         // Incoming bits, MSB first

    assign lr = 1'b0;                                 // Microphone answers in left half

    assign sck_tick = (div_cnt == i2s_sck_half - 1);
    assign sck_fall = sck_tick &  sck;
    assign sck_rise = sck_tick & ~sck;
    assign bit_next = bit_cnt + 6'd1;                 // Wraps at 64

    // --------------------------------------------------
    // sck and ws generation

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            ws      <= 1'b0;
        end
        else
        begin
            if (sck_tick)
            begin
                div_cnt <= '0;
                sck     <= ~sck;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (sck_fall)
            begin
                bit_cnt <= bit_next;
                ws      <= bit_next[5];               // Low for 0..31, high for 32..63
            end
        end
    end

    // --------------------------------------------------
    // Data capture

    // Bits 1..24 of the left half hold the sample, bit 0 is the I2S delay slot
    always_ff @(posedge clk)
    begin
        if (sck_rise && !ws && bit_cnt >= 1 && bit_cnt <= w_mic)
            shift <= {shift[w_mic - 2:0], sd};        // MSB shifts in first
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            value        <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= 1'b0;
            if (sck_fall && bit_next == 6'd32)        // ws rises, left half done
            begin
                value        <= shift;
                sample_valid <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/peak_level_meter.sv ====
`timescale 1ns/1ps

module peak_level_meter
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            slow_clk,     // Refresh square wave, other domain
    input  logic                            clear,        // Drops peak and display
    input  logic [board_pkg::w_mic - 1:0]   value,        // Two's complement sample
    input  logic                            sample_valid,
    output logic [board_pkg::w_level - 1:0] level_hex,    // Latched peak for the display
    output logic [board_pkg::w_top_led - 1:0] led_bar     // Thermometer of level_hex
);

    import board_pkg::*;

    logic [w_mic - 1:0]   mag;                        // Absolute value of sample
    logic [w_level - 1:0] mag_top;                    // Upper bits of the magnitude
    logic [w_level - 1:0] peak;                       // Largest magnitude since clear
    logic [2:0]           slow_sync;                  // Two sync flops plus edge history
    logic                 refresh;                    // Rising edge of slow_clk

    // --------------------------------------------------
    // Magnitude

    always_comb
    begin
        if (!value[w_mic - 1])
            mag = value;                              // Positive, as is
        else if (value == {1'b1, {(w_mic - 1){1'b0}}})
            mag = {1'b0, {(w_mic - 1){1'b1}}};        // Most negative code saturates
        else
            mag = -value;                             // Negate
    end

    assign mag_top = mag[w_mic - 1 -: w_level];

    // --------------------------------------------------
    // Peak hold

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            peak <= '0;
        else if (clear)
            peak <= '0;                               // Key wins over a new sample
        else if (sample_valid && mag_top > peak)
            peak <= mag_top;
    end

    // --------------------------------------------------
    // Display latch on refresh

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            slow_sync <= '0;
        else
            slow_sync <= {slow_sync[1:0], slow_clk};
    end

    assign refresh = slow_sync[1] & ~slow_sync[2];    // Synchronized rise

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            level_hex <= '0;
        else if (clear)
            level_hex <= '0;
        else if (refresh)
            level_hex <= peak;
    end

    // LED k lights at 2**(k+2) and above
    for (genvar k = 0; k < w_top_led; k++)
    begin : g_bar
        assign led_bar[k] = (level_hex >= w_level'(1 << (k + 2)));
    end

endmodule

// ==== hdl/seven_seg_scanner.sv ====
`timescale 1ns/1ps

module seven_seg_scanner
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic [board_pkg::w_level - 1:0] hex_digits, // Four nibbles, digit 0 lowest
    output logic [7:0]                      abcdefgh,   // Segments a..g, h is bit 0
    output logic [board_pkg::w_digit - 1:0] digit       // One-hot selected digit
);

    import board_pkg::*;

    logic [$clog2(scan_cycles) - 1:0] scan_cnt;       // Dwell time on one digit
    logic [$clog2(w_digit) - 1:0]     sel;            // Index of selected digit
    logic [3:0]                       nibble;         // Value shown on selected digit
    logic [6:0]                       seg;            // a..g, a in bit 6

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt <= '0;
            sel      <= '0;                           // Digit 0 first
        end
        else if (scan_cnt == scan_cycles - 1)
        begin
            scan_cnt <= '0;
            sel      <= sel + 1'b1;                   // 0,1,2,3 then wraps
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign digit  = w_digit'(1) << sel;
    assign nibble = hex_digits[{sel, 2'b00} +: 4];

    // --------------------------------------------------
    // Hex to segment decode, active high

    always_comb
    begin
        case (nibble)
            4'h0: seg = 7'b1111110;
            4'h1: seg = 7'b0110000;
            4'h2: seg = 7'b1101101;
            4'h3: seg = 7'b1111001;
            4'h4: seg = 7'b0110011;
            4'h5: seg = 7'b1011011;
            4'h6: seg = 7'b1011111;
            4'h7: seg = 7'b1110000;
            4'h8: seg = 7'b1111111;
            4'h9: seg = 7'b1111011;
            4'ha: seg = 7'b1110111;
            4'hb: seg = 7'b0011111;                   // Lower case b
            4'hc: seg = 7'b1001110;
            4'hd: seg = 7'b0111101;                   // Lower case d
            4'he: seg = 7'b1001111;
            default: seg = 7'b1000111;                // F
        endcase
    end

    // Decimal point flags a zero nibble
    assign abcdefgh = {seg, nibble == 4'h0};

endmodule

// ==== hdl/slow_clk_gen.sv ====
`timescale 1ns/1ps

module slow_clk_gen
#(
    parameter int fast_clk_mhz = board_pkg::clk_mhz,  // Input clock rate, MHz
    parameter int slow_clk_hz  = board_pkg::refresh_hz // Output square wave rate, Hz
)
(
    input  logic clk,
    input  logic rst,
    output logic slow_clk
);

    // Cycles per half period of the output
    localparam int half_period = fast_clk_mhz * 1000000 / slow_clk_hz / 2;

    logic [$clog2(half_period) - 1:0] cnt;            // Half period counter

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt      <= '0;
            slow_clk <= 1'b0;                         // Starts low
        end
        else if (cnt == half_period - 1)
        begin
            cnt      <= '0;                           // Wrap
            slow_clk <= ~slow_clk;                    // Toggle each half period
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== hdl/top.sv ====
`timescale 1ns/1ps

module top
(
    input  logic                              clk,
    input  logic                              slow_clk,  // Display refresh tick
    input  logic                              rst,
    input  logic [board_pkg::w_key - 1:0]     key,       // Active high, key[0] clears
    input  logic [board_pkg::w_sw - 2:0]      sw,        // Not used by this lab
    output logic [board_pkg::w_top_led - 1:0] led,       // Level bar
    output logic [7:0]                        abcdefgh,
    output logic [board_pkg::w_digit - 1:0]   digit,
    output logic                              lr,        // To microphone L/R pin
    output logic                              ws,
    output logic                              sck,
    input  logic                              sd
);

    import board_pkg::*;

    logic [w_mic - 1:0]   mic_value;                  // Latest left sample
    logic                 mic_valid;                  // New sample strobe
    logic [w_level - 1:0] level_hex;                  // Held peak for the digits

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk          (clk),
        .rst          (rst),
        .lr           (lr),
        .ws           (ws),
        .sck          (sck),
        .sd           (sd),
        .value        (mic_value),
        .sample_valid (mic_valid)
    );

    peak_level_meter i_meter
    (
        .clk          (clk),
        .rst          (rst),
        .slow_clk     (slow_clk),
        .clear        (key[0]),
        .value        (mic_value),
        .sample_valid (mic_valid),
        .level_hex    (level_hex),
        .led_bar      (led)
    );

    seven_seg_scanner i_scanner
    (
        .clk        (clk),
        .rst        (rst),
        .hex_digits (level_hex),
        .abcdefgh   (abcdefgh),
        .digit      (digit)
    );

endmodule

// ==== sim.f ====
hdl/board_pkg.sv
hdl/slow_clk_gen.sv
hdl/inmp441_mic_i2s_receiver.sv
hdl/peak_level_meter.sv
hdl/seven_seg_scanner.sv
hdl/top.sv
hdl/board_specific_top.sv
verif/board_checker.sv
verif/tb_board.sv

// ==== verif/board_checker.sv ====
`timescale 1ns/1ps

module board_checker
(
    input  logic        clk,
    input  logic        check,                        // One cycle request from the stimulus
    input  int          test_id,
    input  logic [15:0] exp_level,                    // Model peak expected on the digits
    input  logic [6:0]  hex0,
    input  logic [6:0]  hex1,
    input  logic [6:0]  hex2,
    input  logic [6:0]  hex3,
    input  logic [9:0]  ledr,
    input  logic [7:0]  ledg,
    input  logic        mic_lr,                       // GPIO[0], channel select
    input  logic        mic_gnd,                      // GPIO[1], microphone ground
    input  logic        mic_vdd,                      // GPIO[3], microphone supply
    output int          tests_run,
    output int          tests_failed
);

    // Board pattern, active low, segment a in bit 0 and g in bit 6
    function automatic logic [6:0] hex_pattern(input logic [3:0] nib);
        case (nib)
            4'h0: hex_pattern = 7'h40;
            4'h1: hex_pattern = 7'h79;
            4'h2: hex_pattern = 7'h24;
            4'h3: hex_pattern = 7'h30;
            4'h4: hex_pattern = 7'h19;
            4'h5: hex_pattern = 7'h12;
            4'h6: hex_pattern = 7'h02;
            4'h7: hex_pattern = 7'h78;
            4'h8: hex_pattern = 7'h00;
            4'h9: hex_pattern = 7'h10;
            4'ha: hex_pattern = 7'h08;
            4'hb: hex_pattern = 7'h03;                // Lower case b
            4'hc: hex_pattern = 7'h46;
            4'hd: hex_pattern = 7'h21;                // Lower case d
            4'he: hex_pattern = 7'h06;
            default: hex_pattern = 7'h0e;             // F
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [15:0] got,
                                 input logic [15:0] exp, inout int bad);
        if (got !== exp)
        begin
            $display("FAILED test %0d %s got 0x%0h expected 0x%0h", test_id, name, got, exp);
            bad++;
        end
    endtask

    initial
    begin
        tests_run    = 0;
        tests_failed = 0;
    end

    // --------------------------------------------------
    // Pin comparison at each check instant

    always @(posedge clk)
    begin : compare
        int          bad;
        logic [13:0] bar;                             // Expected thermometer
        logic [3:0]  dp;                              // Expected decimal points
        if (check)
        begin
            bad = 0;
            for (int k = 0; k < 14; k++)
                bar[k] = (int'(exp_level) >= (1 << (k + 2)));   // LED k at 2**(k+2)
            for (int n = 0; n < 4; n++)
                dp[n] = (exp_level[n * 4 +: 4] == 4'h0);        // Lit on a zero nibble
            compare_field("HEX0", hex0, hex_pattern(exp_level[3:0]), bad);
            compare_field("HEX1", hex1, hex_pattern(exp_level[7:4]), bad);
            compare_field("HEX2", hex2, hex_pattern(exp_level[11:8]), bad);
            compare_field("HEX3", hex3, hex_pattern(exp_level[15:12]), bad);
            compare_field("LEDR[9:6]", ledr[9:6], dp, bad);
            compare_field("LEDR[5:0]", ledr[5:0], bar[13:8], bad);  // Upper bar
            compare_field("LEDG", ledg, bar[7:0], bad);
            compare_field("GPIO[0]", mic_lr, 1'b0, bad);            // Left channel
            compare_field("GPIO[1]", mic_gnd, 1'b0, bad);
            compare_field("GPIO[3]", mic_vdd, 1'b1, bad);
            tests_run++;
            if (bad == 0)
                $display("test %0d: level 0x%04h ok", test_id, exp_level);
            else
            begin
                tests_failed++;
                $display("test %0d: level 0x%04h, %0d pins wrong", test_id, exp_level, bad);
            end
        end
    end

endmodule

// ==== verif/tb_board.sv ====
`timescale 1ns/1ps

module tb_board;

    import board_pkg::*;

    localparam int frame_cycles  = 64 * 2 * i2s_sck_half;    // One ws frame, 512
    localparam int idle_cycles   = 12000;                    // Settling before a check
    localparam int n_tests       = 6;
    localparam int sample_frames = 30 + 20 + 6 + 20 + 1;     // Samples over all tests
    localparam int cycle_limit   = ((sample_frames + n_tests) * frame_cycles
                                   + n_tests * idle_cycles + 200) * 11 / 10;

    logic                 clk;
    logic                 rst_n;                      // Reset button, low active
    logic [w_key - 1:0]   key;
    logic [w_sw - 1:0]    sw;
    logic                 uart_rx;
    logic                 sd_drv;                     // Microphone data line
    wire  [w_gpio - 1:0]  gpio;
    logic [9:0]           ledr;
    logic [7:0]           ledg;
    logic [6:0]           hex0;
    logic [6:0]           hex1;
    logic [6:0]           hex2;
    logic [6:0]           hex3;
    logic                 check;
    int                   test_id;
    logic [w_level - 1:0] model_peak;                 // Expected held level
    int                   tests_run;
    int                   tests_failed;
    int                   cycle_cnt;
    logic [w_mic - 1:0]   mic_q [$];                  // Samples waiting for a frame
    logic [w_mic - 1:0]   mic_cur;                    // Sample of the current frame
    int                   slot;                       // sck period within the left half
    logic                 sck_prev;
    logic                 ws_prev;

    assign gpio[5] = sd_drv;

    board_specific_top u_dut
    (
        .CLOCK_50_B8A (clk),
        .CPU_RESET_n  (rst_n),
        .KEY          (key),
        .SW           (sw),
        .LEDR         (ledr),
        .LEDG         (ledg),
        .HEX0         (hex0),
        .HEX1         (hex1),
        .HEX2         (hex2),
        .HEX3         (hex3),
        .UART_RX      (uart_rx),
        .GPIO         (gpio)
    );

    board_checker u_check
    (
        .clk          (clk),
        .check        (check),
        .test_id      (test_id),
        .exp_level    (model_peak),
        .hex0         (hex0),
        .hex1         (hex1),
        .hex2         (hex2),
        .hex3         (hex3),
        .ledr         (ledr),
        .ledg         (ledg),
        .mic_lr       (gpio[0]),
        .mic_gnd      (gpio[1]),
        .mic_vdd      (gpio[3]),
        .tests_run    (tests_run),
        .tests_failed (tests_failed)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;                       // 50 MHz
    end

    // --------------------------------------------------
    // Microphone model, updates sd after each sck fall

    initial
    begin : mic_model
        mic_cur  = '0;
        slot     = 0;
        sck_prev = 1'b0;
        ws_prev  = 1'b0;
        forever
        begin
            @(negedge clk);
            if (sck_prev && !gpio[4])                 // sck fell on the last rising edge
            begin
                if (ws_prev && !gpio[2])              // ws fell with it, new frame
                begin
                    slot = 0;                         // I2S delay slot
                    if (mic_q.size() != 0)
                        mic_cur = mic_q.pop_front();
                    else
                        mic_cur = '0;                 // Silence when idle
                end
                else
                    slot++;
                sd_drv = (!gpio[2] && slot >= 1 && slot <= w_mic) ? mic_cur[w_mic - slot] : 1'b0;
            end
            sck_prev = gpio[4];
            ws_prev  = gpio[2];
        end
    end

    // Displayed level of one sample, magnitude clipped to the largest positive code
    function automatic logic [w_level - 1:0] level_of(input logic [w_mic - 1:0] s);
        int v;
        v = s;
        if (s[w_mic - 1])
            v = v - (1 << w_mic);                     // Sign extend
        if (v < 0)
            v = -v;
        if (v > (1 << (w_mic - 1)) - 1)
            v = (1 << (w_mic - 1)) - 1;
        return v >> (w_mic - w_level);                // Keep the top bits
    endfunction

    task automatic send_sample(input logic [w_mic - 1:0] s);
        @(negedge clk);
        mic_q.push_back(s);
        if (level_of(s) > model_peak)
            model_peak = level_of(s);
    endtask

    task automatic settle_and_check(input int id);
        while (mic_q.size() != 0)
            @(negedge clk);
        repeat (idle_cycles) @(negedge clk);          // Last frame, refresh and scan
        test_id = id;
        check   = 1'b1;
        @(negedge clk);
        check   = 1'b0;
    endtask

    task automatic press_clear;
        @(negedge clk);
        key[0] = 1'b0;                                // KEY pins are low when pressed
        repeat (4) @(negedge clk);
        key[0]     = 1'b1;
        model_peak = '0;
    endtask

    // --------------------------------------------------
    // Stimulus

    initial
    begin : stimulus
        int seed_dummy;
        seed_dummy = $urandom(32'h0103b21a);
        rst_n      = 1'b0;
        key        = '1;
        sw         = '0;
        uart_rx    = 1'b1;
        sd_drv     = 1'b0;
        check      = 1'b0;
        test_id    = 0;
        model_peak = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        settle_and_check(1);                          // Zero display, all dp lit
        for (int i = 0; i < 30; i++)
            send_sample({1'b0, 23'($urandom)});
        settle_and_check(2);
        for (int i = 0; i < 20; i++)
            send_sample((i == 10) ? 24'h800000 : {1'b1, 23'($urandom)});
        settle_and_check(3);
        send_sample(24'h7fffff);
        for (int i = 0; i < 5; i++)
            send_sample({8'h00, 16'($urandom)});      // Held peak must stay
        settle_and_check(4);
        press_clear();
        for (int i = 0; i < 20; i++)
            send_sample({4'h0, 20'($urandom)});
        settle_and_check(5);
        press_clear();
        send_sample(24'h005000);                      // Level 0050, mixed zero nibbles
        settle_and_check(6);
        @(negedge clk);
        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0 && tests_run == n_tests)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
